/* decode_pkg.sv */
`default_nettype none

package decode_pkg;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0] OP_SLTI  = 10'h008;
    localparam logic [9:0] OP_SLTUI = 10'h009;
    localparam logic [9:0] OP_ADDIW = 10'h00a;
    localparam logic [9:0] OP_ANDI  = 10'h00d;
    localparam logic [9:0] OP_ORI   = 10'h00e;
    localparam logic [9:0] OP_XORI  = 10'h00f;
    localparam logic [9:0] OP_LDB   = 10'h0a0;
    localparam logic [9:0] OP_LDH   = 10'h0a1;
    localparam logic [9:0] OP_LDW   = 10'h0a2;
    localparam logic [9:0] OP_STB   = 10'h0a4;
    localparam logic [9:0] OP_STH   = 10'h0a5;
    localparam logic [9:0] OP_STW   = 10'h0a6;
    localparam logic [9:0] OP_LDBU  = 10'h0a8;
    localparam logic [9:0] OP_LDHU  = 10'h0a9;

    // 3R opcodes, inst[31:15]
    localparam logic [16:0] OP_ADDW = 17'h00020;
    localparam logic [16:0] OP_SUBW = 17'h00022;
    localparam logic [16:0] OP_SLT  = 17'h00024;
    localparam logic [16:0] OP_SLTU = 17'h00025;
    localparam logic [16:0] OP_NOR  = 17'h00028;
    localparam logic [16:0] OP_AND  = 17'h00029;
    localparam logic [16:0] OP_OR   = 17'h0002a;
    localparam logic [16:0] OP_XOR  = 17'h0002b;

    localparam logic [7:0] ALU_NOP   = 8'h00;
    localparam logic [7:0] ALU_ADDW  = 8'h01;  // register-register group
    localparam logic [7:0] ALU_SUBW  = 8'h02;
    localparam logic [7:0] ALU_SLT   = 8'h03;
    localparam logic [7:0] ALU_SLTU  = 8'h04;
    localparam logic [7:0] ALU_NOR   = 8'h05;
    localparam logic [7:0] ALU_AND   = 8'h06;
    localparam logic [7:0] ALU_OR    = 8'h07;
    localparam logic [7:0] ALU_XOR   = 8'h08;
    localparam logic [7:0] ALU_SLTI  = 8'h10;  // immediate group
    localparam logic [7:0] ALU_SLTUI = 8'h11;
    localparam logic [7:0] ALU_ADDIW = 8'h12;
    localparam logic [7:0] ALU_ANDI  = 8'h13;
    localparam logic [7:0] ALU_ORI   = 8'h14;
    localparam logic [7:0] ALU_XORI  = 8'h15;
    localparam logic [7:0] ALU_LDB   = 8'h20;  // memory group
    localparam logic [7:0] ALU_LDH   = 8'h21;
    localparam logic [7:0] ALU_LDW   = 8'h22;
    localparam logic [7:0] ALU_LDBU  = 8'h23;
    localparam logic [7:0] ALU_LDHU  = 8'h24;
    localparam logic [7:0] ALU_STB   = 8'h25;
    localparam logic [7:0] ALU_STH   = 8'h26;
    localparam logic [7:0] ALU_STW   = 8'h27;

    localparam logic [2:0] ALU_SEL_NOP        = 3'd0;
    localparam logic [2:0] ALU_SEL_ARITHMETIC = 3'd1;
    localparam logic [2:0] ALU_SEL_LOAD_STORE = 3'd2;

    localparam logic [6:0] EXCEPTION_INE = 7'h0d;  // instruction not exist

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [7:0]  aluop;
        logic [2:0]  alusel;
        logic [31:0] imm;
        logic        reg1_read_en;
        logic [4:0]  reg1_read_addr;
        logic        reg2_read_en;
        logic [4:0]  reg2_read_addr;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        logic        is_exception;
        logic [6:0]  exception_cause;
    } dec_t;

endpackage

`default_nettype wire

/* id_2ri12.sv */
`timescale 1ns/1ns
`default_nettype none

module id_2ri12
    import decode_pkg::*;
(
    input  fetch_t fetch,
    output dec_t   dec,
    output logic   hit
);

    typedef enum logic [2:0] {
        K_NONE,
        K_ALU_ZEXT,
        K_ALU_SEXT,
        K_LOAD,
        K_STORE
    } kind_t;

    logic [9:0]  opcode;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic [11:0] imm12;
    logic [7:0]  aluop;
    kind_t       kind;

    assign opcode = fetch.inst[31:22];
    assign rj     = fetch.inst[9:5];
    assign rd     = fetch.inst[4:0];
    assign imm12  = fetch.inst[21:10];

    always_comb begin
        case (opcode)
            OP_SLTI:  aluop = ALU_SLTI;
            OP_SLTUI: aluop = ALU_SLTUI;
            OP_ADDIW: aluop = ALU_ADDIW;
            OP_ANDI:  aluop = ALU_ANDI;
            OP_ORI:   aluop = ALU_ORI;
            OP_XORI:  aluop = ALU_XORI;
            OP_LDB:   aluop = ALU_LDB;
            OP_LDH:   aluop = ALU_LDH;
            OP_LDW:   aluop = ALU_LDW;
            OP_LDBU:  aluop = ALU_LDBU;
            OP_LDHU:  aluop = ALU_LDHU;
            OP_STB:   aluop = ALU_STB;
            OP_STH:   aluop = ALU_STH;
            OP_STW:   aluop = ALU_STW;
            default:  aluop = ALU_NOP;
        endcase
    end

    // operand handling class per opcode
    always_comb begin
        case (opcode)
            OP_ANDI, OP_ORI, OP_XORI:                 kind = K_ALU_ZEXT;
            OP_SLTI, OP_SLTUI, OP_ADDIW:              kind = K_ALU_SEXT;
            OP_LDB, OP_LDH, OP_LDW, OP_LDBU, OP_LDHU: kind = K_LOAD;
            OP_STB, OP_STH, OP_STW:                   kind = K_STORE;
            default:                                  kind = K_NONE;
        endcase
    end

    assign hit = (kind != K_NONE);

    always_comb begin
        dec        = '0;
        dec.pc     = fetch.pc;
        dec.inst   = fetch.inst;
        dec.aluop  = aluop;
        dec.alusel = ALU_SEL_NOP;
        if (hit) begin
            dec.reg1_read_en   = 1'b1;  // every 2RI12 op reads rj
            dec.reg1_read_addr = rj;
        end
        case (kind)
            K_ALU_ZEXT: begin
                dec.alusel         = ALU_SEL_ARITHMETIC;
                dec.imm            = {20'b0, imm12};
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = rd;
            end
            K_ALU_SEXT: begin
                dec.alusel         = ALU_SEL_ARITHMETIC;
                dec.imm            = {{20{imm12[11]}}, imm12};
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = rd;
            end
            K_LOAD: begin
                dec.alusel         = ALU_SEL_LOAD_STORE;
                dec.imm            = {{20{imm12[11]}}, imm12};
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = rd;
            end
            K_STORE: begin
                dec.alusel         = ALU_SEL_LOAD_STORE;
                dec.reg2_read_en   = 1'b1;  // store data comes from rd
                dec.reg2_read_addr = rd;
            end
            default: begin
                dec.alusel = ALU_SEL_NOP;
            end
        endcase
    end

endmodule

`default_nettype wire

/* id_3r.sv */
`timescale 1ns/1ns
`default_nettype none

module id_3r
    import decode_pkg::*;
(
    input  fetch_t fetch,
    output dec_t   dec,
    output logic   hit
);

    logic [16:0] opcode;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic [7:0]  aluop;

    assign opcode = fetch.inst[31:15];
    assign rk     = fetch.inst[14:10];
    assign rj     = fetch.inst[9:5];
    assign rd     = fetch.inst[4:0];

    always_comb begin
        case (opcode)
            OP_ADDW: aluop = ALU_ADDW;
            OP_SUBW: aluop = ALU_SUBW;
            OP_SLT:  aluop = ALU_SLT;
            OP_SLTU: aluop = ALU_SLTU;
            OP_NOR:  aluop = ALU_NOR;
            OP_AND:  aluop = ALU_AND;
            OP_OR:   aluop = ALU_OR;
            OP_XOR:  aluop = ALU_XOR;
            default: aluop = ALU_NOP;
        endcase
    end

    // no 3R op maps onto the nop code
    assign hit = (aluop != ALU_NOP);

    always_comb begin
        dec        = '0;
        dec.pc     = fetch.pc;
        dec.inst   = fetch.inst;
        dec.aluop  = aluop;
        dec.alusel = ALU_SEL_NOP;
        if (hit) begin
            dec.alusel         = ALU_SEL_ARITHMETIC;
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg2_read_en   = 1'b1;
            dec.reg2_read_addr = rk;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
        end
    end

endmodule

`default_nettype wire

/* id_select.sv */
`timescale 1ns/1ns
`default_nettype none

module id_select
    import decode_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   fetch_valid,
    input  fetch_t fetch,
    input  dec_t   dec_2ri12,
    input  logic   hit_2ri12,
    input  dec_t   dec_3r,
    input  logic   hit_3r,
    output logic   id_valid,
    output dec_t   id_out
);

    dec_t dec_next;

    always_comb begin
        if (hit_2ri12) begin
            dec_next = dec_2ri12;
        end else if (hit_3r) begin
            dec_next = dec_3r;
        end else begin
            dec_next                 = '0;
            dec_next.pc              = fetch.pc;
            dec_next.inst            = fetch.inst;
            dec_next.aluop           = ALU_NOP;
            dec_next.alusel          = ALU_SEL_NOP;
            dec_next.is_exception    = 1'b1;  // unknown word
            dec_next.exception_cause = EXCEPTION_INE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
            id_out   <= '0;
        end else begin
            id_valid <= fetch_valid;
            if (fetch_valid) begin
                id_out <= dec_next;  // holds over idle cycles
            end
        end
    end

    // the two opcode spaces must stay disjoint
    a_one_hit: assert property (
        @(posedge clk) disable iff (reset)
        fetch_valid |-> !(hit_2ri12 && hit_3r)
    );

    a_exc_no_write: assert property (
        @(posedge clk) disable iff (reset)
        !(id_out.is_exception && id_out.reg_write_en)
    );

    a_reset_valid: assert property (
        @(posedge clk)
        reset |=> !id_valid
    );

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage
    import decode_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   fetch_valid,
    input  fetch_t fetch,
    output logic   id_valid,
    output dec_t   id_out
);

    dec_t dec_2ri12;
    dec_t dec_3r;
    logic hit_2ri12;
    logic hit_3r;

    id_2ri12 u_id_2ri12 (
        .fetch (fetch),
        .dec   (dec_2ri12),
        .hit   (hit_2ri12)
    );

    id_3r u_id_3r (
        .fetch (fetch),
        .dec   (dec_3r),
        .hit   (hit_3r)
    );

    id_select u_id_select (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .dec_2ri12   (dec_2ri12),
        .hit_2ri12   (hit_2ri12),
        .dec_3r      (dec_3r),
        .hit_3r      (hit_3r),
        .id_valid    (id_valid),
        .id_out      (id_out)
    );

endmodule

`default_nettype wire

/* tb_id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage
    import decode_pkg::*;
();

    logic   clk;
    logic   reset;
    logic   fetch_valid;
    fetch_t fetch;
    logic   id_valid;
    dec_t   id_out;

    int   mismatch_errors;
    int   timeout_errors;
    int   wait_limit = 8;  // cycles before a wait gives up
    dec_t last_exp;        // last result that id_out should hold

    logic [9:0]  imm_ops [6] = '{OP_SLTI, OP_SLTUI, OP_ADDIW, OP_ANDI, OP_ORI, OP_XORI};
    logic [9:0]  mem_ops [8] = '{OP_LDB, OP_LDH, OP_LDW, OP_LDBU, OP_LDHU,
                                 OP_STB, OP_STH, OP_STW};
    logic [16:0] rr_ops  [8] = '{OP_ADDW, OP_SUBW, OP_SLT, OP_SLTU,
                                 OP_NOR, OP_AND, OP_OR, OP_XOR};
    logic [9:0]  bad_2ri12 [7] = '{10'h0a3, 10'h0a7, 10'h0aa, 10'h00b, 10'h00c,
                                   10'h010, 10'h3ff};
    logic [16:0] bad_3r [6] = '{17'h21, 17'h23, 17'h26, 17'h27, 17'h2c, 17'h1f};

    id_stage dut (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .id_valid    (id_valid),
        .id_out      (id_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] word_2ri12(input logic [9:0] op, input logic [11:0] imm,
                                                input logic [4:0] rj, input logic [4:0] rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] word_3r(input logic [16:0] op, input logic [4:0] rk,
                                             input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    // reference decode, straight from the format rules
    function automatic dec_t expected_decode(input fetch_t f);
        dec_t        d;
        logic [9:0]  op10;
        logic [16:0] op17;
        op10   = f.inst[31:22];
        op17   = f.inst[31:15];
        d      = '0;
        d.pc   = f.pc;
        d.inst = f.inst;
        case (op10)
            OP_SLTI:  d.aluop = ALU_SLTI;
            OP_SLTUI: d.aluop = ALU_SLTUI;
            OP_ADDIW: d.aluop = ALU_ADDIW;
            OP_ANDI:  d.aluop = ALU_ANDI;
            OP_ORI:   d.aluop = ALU_ORI;
            OP_XORI:  d.aluop = ALU_XORI;
            OP_LDB:   d.aluop = ALU_LDB;
            OP_LDH:   d.aluop = ALU_LDH;
            OP_LDW:   d.aluop = ALU_LDW;
            OP_LDBU:  d.aluop = ALU_LDBU;
            OP_LDHU:  d.aluop = ALU_LDHU;
            OP_STB:   d.aluop = ALU_STB;
            OP_STH:   d.aluop = ALU_STH;
            OP_STW:   d.aluop = ALU_STW;
            default:  d.aluop = ALU_NOP;
        endcase
        if (d.aluop != ALU_NOP) begin
            d.reg1_read_en   = 1'b1;
            d.reg1_read_addr = f.inst[9:5];
            if (op10 inside {OP_STB, OP_STH, OP_STW}) begin
                d.alusel         = ALU_SEL_LOAD_STORE;
                d.reg2_read_en   = 1'b1;
                d.reg2_read_addr = f.inst[4:0];
            end else begin
                d.reg_write_en   = 1'b1;
                d.reg_write_addr = f.inst[4:0];
                if (op10 inside {OP_ANDI, OP_ORI, OP_XORI})
                    d.imm = {20'b0, f.inst[21:10]};
                else
                    d.imm = {{20{f.inst[21]}}, f.inst[21:10]};
                if (op10 inside {OP_SLTI, OP_SLTUI, OP_ADDIW, OP_ANDI, OP_ORI, OP_XORI})
                    d.alusel = ALU_SEL_ARITHMETIC;
                else
                    d.alusel = ALU_SEL_LOAD_STORE;
            end
            return d;
        end
        case (op17)
            OP_ADDW: d.aluop = ALU_ADDW;
            OP_SUBW: d.aluop = ALU_SUBW;
            OP_SLT:  d.aluop = ALU_SLT;
            OP_SLTU: d.aluop = ALU_SLTU;
            OP_NOR:  d.aluop = ALU_NOR;
            OP_AND:  d.aluop = ALU_AND;
            OP_OR:   d.aluop = ALU_OR;
            OP_XOR:  d.aluop = ALU_XOR;
            default: d.aluop = ALU_NOP;
        endcase
        if (d.aluop != ALU_NOP) begin
            d.alusel         = ALU_SEL_ARITHMETIC;
            d.reg1_read_en   = 1'b1;
            d.reg1_read_addr = f.inst[9:5];
            d.reg2_read_en   = 1'b1;
            d.reg2_read_addr = f.inst[14:10];
            d.reg_write_en   = 1'b1;
            d.reg_write_addr = f.inst[4:0];
        end else begin
            d.is_exception    = 1'b1;  // neither format knows the word
            d.exception_cause = EXCEPTION_INE;
        end
        return d;
    endfunction

    task automatic report_mismatch(input string what, input string field,
                                   input logic [31:0] got, input logic [31:0] exp);
        mismatch_errors++;
        $display("Mismatch at %0t: %s %s got %h expected %h", $time, what, field, got, exp);
    endtask

    task automatic check_dec(input dec_t got, input dec_t exp, input string what);
        if (got.pc !== exp.pc) report_mismatch(what, "pc", got.pc, exp.pc);
        if (got.inst !== exp.inst) report_mismatch(what, "inst", got.inst, exp.inst);
        if (got.aluop !== exp.aluop)
            report_mismatch(what, "aluop", 32'(got.aluop), 32'(exp.aluop));
        if (got.alusel !== exp.alusel)
            report_mismatch(what, "alusel", 32'(got.alusel), 32'(exp.alusel));
        if (got.imm !== exp.imm) report_mismatch(what, "imm", got.imm, exp.imm);
        if (got.reg1_read_en !== exp.reg1_read_en)
            report_mismatch(what, "reg1_read_en", 32'(got.reg1_read_en), 32'(exp.reg1_read_en));
        if (got.reg1_read_addr !== exp.reg1_read_addr)
            report_mismatch(what, "reg1_read_addr", 32'(got.reg1_read_addr),
                            32'(exp.reg1_read_addr));
        if (got.reg2_read_en !== exp.reg2_read_en)
            report_mismatch(what, "reg2_read_en", 32'(got.reg2_read_en), 32'(exp.reg2_read_en));
        if (got.reg2_read_addr !== exp.reg2_read_addr)
            report_mismatch(what, "reg2_read_addr", 32'(got.reg2_read_addr),
                            32'(exp.reg2_read_addr));
        if (got.reg_write_en !== exp.reg_write_en)
            report_mismatch(what, "reg_write_en", 32'(got.reg_write_en), 32'(exp.reg_write_en));
        if (got.reg_write_addr !== exp.reg_write_addr)
            report_mismatch(what, "reg_write_addr", 32'(got.reg_write_addr),
                            32'(exp.reg_write_addr));
        if (got.is_exception !== exp.is_exception)
            report_mismatch(what, "is_exception", 32'(got.is_exception), 32'(exp.is_exception));
        if (got.exception_cause !== exp.exception_cause)
            report_mismatch(what, "exception_cause", 32'(got.exception_cause),
                            32'(exp.exception_cause));
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_errors++;
            $display("Mismatch at %0t: %s id_valid got %b expected %b", $time, what, got, exp);
        end
    endtask

    // called on a falling edge, returns on a falling edge with fetch_valid low
    task automatic apply_and_check(input fetch_t f, input string what);
        dec_t exp;
        int   cycles;
        exp         = expected_decode(f);
        fetch_valid = 1'b1;
        fetch       = f;
        cycles      = 0;
        do begin
            @(negedge clk);
            fetch_valid = 1'b0;
            fetch       = ~f;  // idle word differs from the item
            cycles++;
        end while (!id_valid && cycles < wait_limit);
        if (!id_valid) begin
            timeout_errors++;
            $display("Timeout at %0t: %s never raised id_valid", $time, what);
        end else begin
            if (cycles != 1)
                report_mismatch(what, "latency", 32'(cycles), 32'd1);
            check_dec(id_out, exp, what);
        end
        last_exp = exp;
        @(negedge clk);
        check_valid(id_valid, 1'b0, {what, " idle"});
        check_dec(id_out, exp, {what, " hold"});
    endtask

    task automatic reset_behavior();
        dec_t zero_dec;
        zero_dec = '0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            fetch_valid = 1'b1;  // must be ignored while in reset
            fetch.pc    = $urandom;
            fetch.inst  = word_3r(OP_ADDW, 5'($urandom), 5'($urandom), 5'($urandom));
            check_valid(id_valid, 1'b0, "in reset");
            check_dec(id_out, zero_dec, "in reset");
        end
        reset       = 1'b0;
        fetch_valid = 1'b0;
        @(negedge clk);
        check_valid(id_valid, 1'b0, "after reset");
        check_dec(id_out, zero_dec, "after reset");
        last_exp = zero_dec;
    endtask

    task automatic imm_alu_ops();
        fetch_t     f;
        logic [11:0] imm;
        foreach (imm_ops[i]) begin
            imm    = 12'($urandom) & 12'h7ff;
            f.pc   = $urandom & 32'hffff_fffc;
            f.inst = word_2ri12(imm_ops[i], imm, 5'($urandom), 5'($urandom));
            apply_and_check(f, "imm alu positive");
            imm    = imm | 12'h800;  // top bit set, extension matters
            f.inst = word_2ri12(imm_ops[i], imm, 5'($urandom), 5'($urandom));
            apply_and_check(f, "imm alu negative");
        end
    endtask

    task automatic load_store_ops();
        fetch_t f;
        foreach (mem_ops[i]) begin
            f.pc   = $urandom & 32'hffff_fffc;
            f.inst = word_2ri12(mem_ops[i], 12'($urandom), 5'($urandom), 5'($urandom));
            apply_and_check(f, "load/store");
            f.inst = word_2ri12(mem_ops[i], 12'h800 | 12'($urandom), 5'($urandom),
                                5'($urandom));
            apply_and_check(f, "load/store negative");
        end
    endtask

    task automatic reg_reg_ops();
        fetch_t f;
        foreach (rr_ops[i]) begin
            f.pc   = $urandom & 32'hffff_fffc;
            f.inst = word_3r(rr_ops[i], 5'($urandom), 5'($urandom), 5'($urandom));
            apply_and_check(f, "3r op");
        end
    endtask

    task automatic unknown_words();
        fetch_t f;
        foreach (bad_2ri12[i]) begin
            f.pc   = $urandom;
            f.inst = word_2ri12(bad_2ri12[i], 12'($urandom), 5'($urandom), 5'($urandom));
            apply_and_check(f, "unknown 2ri12");
        end
        foreach (bad_3r[i]) begin
            f.pc   = $urandom;
            f.inst = word_3r(bad_3r[i], 5'($urandom), 5'($urandom), 5'($urandom));
            apply_and_check(f, "unknown 3r");
        end
        f.inst = 32'h0000_0000;
        apply_and_check(f, "all zero word");
        f.inst = 32'hffff_ffff;
        apply_and_check(f, "all ones word");
    endtask

    task automatic random_stream();
        fetch_t     f;
        logic       valid;
        logic [2:0] idx;
        int         pick;
        string      what;
        for (int i = 0; i < 200; i++) begin
            pick = int'($urandom % 8);
            idx  = 3'($urandom % 6);
            f.pc = $urandom & 32'hffff_fffc;
            case (pick)
                0, 1:    f.inst = word_2ri12(imm_ops[idx], 12'($urandom), 5'($urandom),
                                             5'($urandom));
                2, 3:    f.inst = word_2ri12(mem_ops[3'($urandom)], 12'($urandom),
                                             5'($urandom), 5'($urandom));
                4, 5:    f.inst = word_3r(rr_ops[3'($urandom)], 5'($urandom), 5'($urandom),
                                          5'($urandom));
                default: f.inst = $urandom;  // mostly unknown words
            endcase
            valid       = (pick != 7);
            fetch_valid = valid;
            fetch       = f;  // idle cycles still carry garbage
            @(negedge clk);
            check_valid(id_valid, valid, "stream");
            if (valid) begin
                last_exp = expected_decode(f);
                what     = "stream item";
            end else begin
                what = "stream idle hold";
            end
            check_dec(id_out, last_exp, what);
        end
        fetch_valid = 1'b0;
    endtask

    initial begin
        mismatch_errors = 0;
        timeout_errors  = 0;
        void'($urandom(32'hea362142));
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        last_exp    = '0;
        reset_behavior();
        imm_alu_ops();
        load_store_ops();
        reg_reg_ops();
        unknown_words();
        random_stream();
        $display("errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
        if (mismatch_errors == 0 && timeout_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // overall watchdog
    initial begin
        #40000;
        $display("Simulation ran past its time limit and was stopped");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* id_stage.f */
decode_pkg.sv
id_2ri12.sv
id_3r.sv
id_select.sv
id_stage.sv
tb_id_stage.sv

/* run.sh */
#!/usr/bin/env bash
# builds the id_stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        --top-module tb_id_stage --Mdir obj_dir -o sim_id_stage \
        -f id_stage.f; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_id_stage)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Done: no errors" <<< "$sim_out"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
